// ==== noc_pkg.sv ====
// Network flit format for the eastbound router chain.
// A flit is one data word plus the number of the node that consumes it.

package noc_pkg;

    // Width of one flit data word
    localparam int data_w = 32;

    // Node numbers are 2 bits, so the chain holds up to four routers
    localparam int node_w = 2;

    typedef logic [data_w-1:0] data_t;

    typedef logic [node_w-1:0] node_t;

    // Single-flit packet as stored in the router buffers
    typedef struct packed {
        data_t data;
        node_t dest;
    } flit_t;

endpackage

// ==== acc_pkg.sv ====
// Accumulator types for the traffic processors.
// The running sum is two data words wide and is also the final result.

package acc_pkg;

    // Width of a running sum and of the result at the last node
    localparam int sum_w = 64;

    typedef logic [sum_w-1:0] sum_t;

endpackage

// ==== flit_link_if.sv ====
// Credit-controlled flit link between two blocks of the chain.
// The sender raises valid for one cycle per flit and spends a credit.
// The receiver pulses credit once for every buffer slot it frees.

interface flit_link_if;

    logic           valid;
    noc_pkg::data_t data;
    noc_pkg::node_t dest;
    logic           credit;

    // Flit source, holds the credit counter
    modport sender (
        output valid,
        output data,
        output dest,
        input  credit
    );

    // Flit sink, owns the buffer
    modport receiver (
        input  valid,
        input  data,
        input  dest,
        output credit
    );

endinterface

// ==== credit_fifo.sv ====
// Receive buffer for a credit-controlled link.
// Circular buffer with an occupancy count. Space is guaranteed by the
// sender's credits, so a push is always taken. Every pop registers a
// one-cycle credit pulse back to the sender.

module credit_fifo #(
    parameter type payload_t = noc_pkg::data_t,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // Pointer advance with wrap for any depth
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Freed slot goes back to the sender next cycle
            credit <= pop;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

// ==== chain_router.sv ====
// Router for one node of the eastbound chain.
// Buffers the west and local_in links, routes west flits by destination
// to local_out or east, and shares east round-robin between both buffers.
// Outputs are registered and gated by per-link credit counters.

module chain_router #(
    parameter int node_id   = 0,
    parameter int buf_depth = 4
) (
    input  logic          clk,
    input  logic          reset,
    flit_link_if.receiver west,
    flit_link_if.receiver local_in,
    flit_link_if.sender   east,
    flit_link_if.sender   local_out
);

    localparam int cnt_w = $clog2(buf_depth + 1);

    noc_pkg::flit_t   west_in;
    noc_pkg::flit_t   west_head;
    noc_pkg::flit_t   local_in_flit;
    noc_pkg::flit_t   local_head;
    logic             west_ne;
    logic             local_ne;
    logic             west_pop;
    logic             local_pop;
    logic             west_is_local;
    logic             west_east_req;
    logic             east_ok;
    logic             local_ok;
    logic             send_local;
    logic             send_east;
    logic             grant_west_east;
    logic             grant_local_east;
    logic             west_prio;
    logic [cnt_w-1:0] east_cnt;
    logic [cnt_w-1:0] local_cnt;
    logic             east_valid;
    logic             local_valid;
    noc_pkg::flit_t   east_flit;
    noc_pkg::flit_t   local_flit;

    assign west_in       = '{data: west.data, dest: west.dest};
    assign local_in_flit = '{data: local_in.data, dest: local_in.dest};

    credit_fifo #(
        .payload_t (noc_pkg::flit_t),
        .depth     (buf_depth)
    ) west_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (west.valid),
        .push_data (west_in),
        .pop       (west_pop),
        .head      (west_head),
        .not_empty (west_ne),
        .credit    (west.credit)
    );

    credit_fifo #(
        .payload_t (noc_pkg::flit_t),
        .depth     (buf_depth)
    ) local_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (local_in.valid),
        .push_data (local_in_flit),
        .pop       (local_pop),
        .head      (local_head),
        .not_empty (local_ne),
        .credit    (local_in.credit)
    );

    // West flits for this node leave on local_out, all others go east
    assign west_is_local = (west_head.dest == noc_pkg::node_t'(node_id));
    assign west_east_req = west_ne && !west_is_local;
    assign east_ok       = (east_cnt != '0);
    assign local_ok      = (local_cnt != '0);
    assign send_local    = west_ne && west_is_local && local_ok;

    // Round-robin for east when both buffers compete
    always_comb begin
        grant_west_east  = 1'b0;
        grant_local_east = 1'b0;
        if (east_ok) begin
            if (west_east_req && local_ne) begin
                grant_west_east  = west_prio;
                grant_local_east = !west_prio;
            end else begin
                grant_west_east  = west_east_req;
                grant_local_east = local_ne;
            end
        end
    end

    assign send_east = grant_west_east || grant_local_east;
    assign west_pop  = send_local || grant_west_east;
    assign local_pop = grant_local_east;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            east_cnt    <= cnt_w'(buf_depth);
            local_cnt   <= cnt_w'(buf_depth);
            east_valid  <= 1'b0;
            local_valid <= 1'b0;
            west_prio   <= 1'b1;
        end else begin
            east_cnt    <= east_cnt - cnt_w'(send_east) + cnt_w'(east.credit);
            local_cnt   <= local_cnt - cnt_w'(send_local) + cnt_w'(local_out.credit);
            east_valid  <= send_east;
            local_valid <= send_local;
            // The buffer just served yields priority
            if (grant_west_east) begin
                west_prio <= 1'b0;
            end else if (grant_local_east) begin
                west_prio <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send_east) begin
            east_flit <= grant_west_east ? west_head : local_head;
        end
        if (send_local) begin
            local_flit <= west_head;
        end
    end

    assign east.valid      = east_valid;
    assign east.data       = east_flit.data;
    assign east.dest       = east_flit.dest;
    assign local_out.valid = local_valid;
    assign local_out.data  = local_flit.data;
    assign local_out.dest  = local_flit.dest;

endmodule

// ==== node_accumulator.sv ====
// Traffic processor attached to one router of the chain.
// Buffers arriving words and adds each one, zero-extended, to a 64-bit sum.
// Middle nodes forward the low word of the new sum to the next node.
// The last node presents the sum as the result, paced by result credits.

module node_accumulator #(
    parameter int node_id   = 1,
    parameter int num_nodes = 4,
    parameter int buf_depth = 4
) (
    input  logic          clk,
    input  logic          reset,
    flit_link_if.receiver in_link,
    flit_link_if.sender   fwd_link,
    output logic          out_valid,
    output acc_pkg::sum_t out_sum,
    input  logic          out_credit
);

    localparam bit is_last = (node_id == num_nodes - 1);
    localparam int cnt_w   = $clog2(buf_depth + 1);

    noc_pkg::data_t   head;
    logic             not_empty;
    logic             pop;
    logic             credit_in;
    logic [cnt_w-1:0] down_cnt;
    acc_pkg::sum_t    sum;
    acc_pkg::sum_t    next_sum;
    logic             send_q;
    noc_pkg::data_t   fwd_data_q;

    // Arriving flits always carry this node's number, so only data is kept
    credit_fifo #(
        .payload_t (noc_pkg::data_t),
        .depth     (buf_depth)
    ) in_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (in_link.valid),
        .push_data (in_link.data),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (in_link.credit)
    );

    // Downstream credits come from the router or from the result sink
    assign credit_in = is_last ? out_credit : fwd_link.credit;
    assign pop       = not_empty && (down_cnt != '0);
    assign next_sum  = sum + {{(acc_pkg::sum_w - noc_pkg::data_w){1'b0}}, head};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            down_cnt <= cnt_w'(buf_depth);
            sum      <= '0;
            send_q   <= 1'b0;
        end else begin
            down_cnt <= down_cnt - cnt_w'(pop) + cnt_w'(credit_in);
            if (pop) begin
                sum <= next_sum;
            end
            send_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            fwd_data_q <= next_sum[noc_pkg::data_w-1:0];
        end
    end

    // New flit toward the next node
    assign fwd_link.valid = send_q && !is_last;
    assign fwd_link.data  = is_last ? '0 : fwd_data_q;
    assign fwd_link.dest  = is_last ? '0 : noc_pkg::node_t'(node_id + 1);

    // Result port, used at the last node only
    assign out_valid = send_q && is_last;
    assign out_sum   = sum;

endmodule

// ==== noc_chain_top.sv ====
// Top level of the eastbound router chain.
// Builds num_nodes routers and a traffic processor at every node after the
// first. Injection enters router 0 local_in and the result leaves the last
// processor, both as plain credit-controlled ports.

module noc_chain_top #(
    parameter int num_nodes = 4,
    parameter int buf_depth = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  noc_pkg::data_t in_data,
    input  noc_pkg::node_t in_dest,
    output logic           in_credit,
    output logic           out_valid,
    output acc_pkg::sum_t  out_sum,
    input  logic           out_credit
);

    // chain_link[i] enters router i from the west, chain_link[i+1] leaves east
    flit_link_if chain_link [num_nodes+1] ();
    // Processor to router, and router to processor, per node
    flit_link_if inj_link [num_nodes] ();
    flit_link_if ej_link [num_nodes] ();

    // Processor outputs, one per node that has a processor
    logic          acc_valid [1:num_nodes-1];
    acc_pkg::sum_t acc_sum [1:num_nodes-1];

    // Nothing arrives from west of router 0
    assign chain_link[0].valid = 1'b0;
    assign chain_link[0].data  = '0;
    assign chain_link[0].dest  = '0;

    // No receiver east of the last router
    assign chain_link[num_nodes].credit = 1'b0;

    // Injection into router 0
    assign inj_link[0].valid = in_valid;
    assign inj_link[0].data  = in_data;
    assign inj_link[0].dest  = in_dest;
    assign in_credit         = inj_link[0].credit;

    // Node 0 has no processor
    assign ej_link[0].credit = 1'b0;

    for (genvar i = 0; i < num_nodes; i++) begin : g_node
        chain_router #(
            .node_id   (i),
            .buf_depth (buf_depth)
        ) router_i (
            .clk       (clk),
            .reset     (reset),
            .west      (chain_link[i]),
            .local_in  (inj_link[i]),
            .east      (chain_link[i+1]),
            .local_out (ej_link[i])
        );

        if (i > 0) begin : g_proc
            node_accumulator #(
                .node_id   (i),
                .num_nodes (num_nodes),
                .buf_depth (buf_depth)
            ) proc_i (
                .clk        (clk),
                .reset      (reset),
                .in_link    (ej_link[i]),
                .fwd_link   (inj_link[i]),
                .out_valid  (acc_valid[i]),
                .out_sum    (acc_sum[i]),
                .out_credit (out_credit)
            );
        end
    end

    // Result from the last processor
    assign out_valid = acc_valid[num_nodes-1];
    assign out_sum   = acc_sum[num_nodes-1];

endmodule

// ==== noc_chain_sva.sv ====
// Protocol checks for the credit-controlled receive buffers.
// Credits must keep every buffer from overflowing or underflowing,
// and no credit pulse may leave a buffer while reset is active.

module credit_fifo_sva #(
    parameter int depth = 4
) (
    input logic                         clk,
    input logic                         reset,
    input logic                         push,
    input logic                         pop,
    input logic                         credit,
    input logic [$clog2(depth + 1)-1:0] count
);

    // A sender with credits never finds the buffer full
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) !(push && count == depth)
    ) else $error("push into a full credit buffer");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) !(pop && count == 0)
    ) else $error("pop from an empty credit buffer");

    no_credit_in_reset: assert property (
        @(posedge clk) reset |-> !credit
    ) else $error("credit pulse during reset");

endmodule

bind credit_fifo credit_fifo_sva #(
    .depth (depth)
) fifo_sva_i (
    .clk    (clk),
    .reset  (reset),
    .push   (push),
    .pop    (pop),
    .credit (credit),
    .count  (count)
);

// ==== noc_chain_tb.sv ====
// Directed testbench for the eastbound router chain.
// Drives injection flits into node 0, returns result credits and checks
// every result against a reference model of the three processor sums.

module noc_chain_tb;

    localparam int num_nodes   = 4;
    localparam int buf_depth   = 4;
    localparam int drive_delay = 10;
    localparam int wait_limit  = 2000;

    logic           clk;
    logic           reset;
    logic           in_valid;
    noc_pkg::data_t in_data;
    noc_pkg::node_t in_dest;
    logic           in_credit;
    logic           out_valid;
    acc_pkg::sum_t  out_sum;
    logic           out_credit;

    // Injection credits held by the testbench and result credits still owed
    int inj_credits;
    int res_owed;
    bit hold_results;
    int errors;
    int timeouts;

    logic [31:0]   lcg_state = 32'd62;
    acc_pkg::sum_t m_sum [1:num_nodes-1];
    acc_pkg::sum_t results [$];
    acc_pkg::sum_t exp_q [$];

    noc_chain_top #(
        .num_nodes (num_nodes),
        .buf_depth (buf_depth)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_dest    (in_dest),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_sum    (out_sum),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (out_valid) begin
            results.push_back(out_sum);
            res_owed++;
        end
        if (in_credit) begin
            inj_credits++;
        end
    end

    // Returns one result credit per cycle unless results are held back
    always @(posedge clk) begin
        #drive_delay;
        if (!hold_results && res_owed > 0) begin
            out_credit = 1'b1;
            res_owed--;
        end else begin
            out_credit = 1'b0;
        end
    end

    function automatic noc_pkg::data_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Word enters the processor at dest, each later node adds the low word
    function automatic acc_pkg::sum_t model_apply(input noc_pkg::data_t word,
                                                  input noc_pkg::node_t dest);
        noc_pkg::data_t carry;
        carry = word;
        for (int n = int'(dest); n < num_nodes; n++) begin
            m_sum[n] = m_sum[n] + acc_pkg::sum_t'(carry);
            carry    = m_sum[n][noc_pkg::data_w-1:0];
        end
        return m_sum[num_nodes-1];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic send_flit(input noc_pkg::data_t word, input noc_pkg::node_t dest);
        int waited;
        waited = 0;
        while (inj_credits == 0 && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (inj_credits == 0) begin
            $display("Timeout: no injection credit came back for a flit to node %0d", dest);
            timeouts++;
            return;
        end
        inj_credits--;
        exp_q.push_back(model_apply(word, dest));
        in_valid = 1'b1;
        in_data  = word;
        in_dest  = dest;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int n, input string what);
        int waited;
        waited = 0;
        while (results.size() < n && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (results.size() < n) begin
            $display("Timeout: only %0d of %0d results arrived in the %s test",
                     results.size(), n, what);
            timeouts++;
        end
    endtask

    task automatic compare_results(input string what);
        acc_pkg::sum_t got;
        acc_pkg::sum_t exp;
        int            idx;
        idx = 0;
        while (results.size() > 0 && exp_q.size() > 0) begin
            got = results.pop_front();
            exp = exp_q.pop_front();
            assert (got == exp) else begin
                $display("CHECK FAILED at %0t: %s result %0d is %h, expected %h",
                         $time, what, idx, got, exp);
                errors++;
            end
            idx++;
        end
        assert (results.size() == 0 && exp_q.size() == 0) else begin
            $display("CHECK FAILED at %0t: %s left %0d results and %0d expected values",
                     $time, what, results.size(), exp_q.size());
            errors++;
        end
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            assert (out_valid == 1'b0 && in_credit == 1'b0) else begin
                $display("CHECK FAILED at %0t: out_valid %b in_credit %b after reset",
                         $time, out_valid, in_credit);
                errors++;
            end
        end
        next_cycle();
    endtask

    task automatic single_to_node1();
        send_flit(next_rand(), 2'd1);
        wait_results(1, "single packet");
        compare_results("single packet");
    endtask

    task automatic bypass_nodes();
        send_flit(next_rand(), 2'd2);
        wait_results(1, "bypass to node 2");
        compare_results("bypass to node 2");
        send_flit(next_rand(), 2'd3);
        wait_results(1, "bypass to node 3");
        compare_results("bypass to node 3");
    endtask

    task automatic stream_twenty();
        int waited;
        waited = 0;
        for (int i = 0; i < 20; i++) begin
            send_flit(next_rand(), 2'd1);
        end
        wait_results(20, "stream");
        compare_results("stream");
        while (inj_credits != buf_depth && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        assert (inj_credits == buf_depth) else begin
            $display("CHECK FAILED at %0t: %0d injection credits returned, expected %0d",
                     $time, inj_credits, buf_depth);
            errors++;
        end
    endtask

    task automatic hold_and_release();
        int waited;
        waited = 0;
        // The last processor must hold all its result credits first
        while (res_owed != 0 && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (res_owed != 0) begin
            $display("Timeout: result credits were still owed before holding results");
            timeouts++;
            return;
        end
        hold_results = 1'b1;
        for (int i = 0; i < 10; i++) begin
            send_flit(next_rand(), 2'd1);
        end
        wait_results(buf_depth, "back-pressure");
        // Observation window with result credits withheld
        repeat (50) begin
            next_cycle();
        end
        assert (results.size() <= buf_depth) else begin
            $display("CHECK FAILED at %0t: %0d results while credit was withheld",
                     $time, results.size());
            errors++;
        end
        hold_results = 1'b0;
        wait_results(10, "back-pressure release");
        compare_results("back-pressure");
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_dest      = '0;
        out_credit   = 1'b0;
        inj_credits  = buf_depth;
        res_owed     = 0;
        hold_results = 1'b0;
        errors       = 0;
        timeouts     = 0;
        for (int n = 1; n < num_nodes; n++) begin
            m_sum[n] = '0;
        end
        repeat (16) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        idle_after_reset();
        if (timeouts == 0) single_to_node1();
        if (timeouts == 0) bypass_nodes();
        if (timeouts == 0) stream_twenty();
        if (timeouts == 0) hold_and_release();

        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== noc_chain.f ====
noc_pkg.sv
acc_pkg.sv
flit_link_if.sv
credit_fifo.sv
chain_router.sv
node_accumulator.sv
noc_chain_top.sv
noc_chain_sva.sv
noc_chain_tb.sv
